/* rtl/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// instruction queue entries, also the credits held by the source after reset
`define CORE_QUEUE_DEPTH 4

// architectural register count
`define CORE_NUM_REGS 16

// data word width
`define CORE_WORD_BITS 32

// program counter width, counted in words
`define CORE_PTR_BITS 30

`endif

/* rtl/core_pkg.sv */
`default_nettype none

`include "core_macros.svh"

package core_pkg;

	// ********************
	// instruction encoding
	//
	// [31:28] class: 0 alu, 1 branch
	// alu:
	//   [27:25] opcode    [24] S (update N/Z)
	//   [23:22] snd mode  [21:18] rd  [17:14] rn
	//   [13:10] r_snd     [9:6] r_shift
	//   [7:0] imm for SND_IMM, [4:0] shift amount for SND_SHIFT_IMM
	// branch:
	//   [23:0] signed word offset from pc + 2
	// ********************

	localparam logic [3:0] CLASS_ALU    = 4'h0;
	localparam logic [3:0] CLASS_BRANCH = 4'h1;

	typedef logic [`CORE_WORD_BITS-1:0] word;
	typedef logic [`CORE_PTR_BITS-1:0]  ptr;
	typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_num;

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_ORR,
		OP_EOR,
		OP_MOV
	} alu_op;

	typedef enum logic [1:0] {
		SND_IMM,
		SND_SHIFT_IMM,
		SND_SHIFT_REG
	} snd_mode;

	typedef struct packed {
		logic       execute;
		logic       branch;
		logic       writeback;
		logic       update_flags;
		alu_op      op;
		snd_mode    snd;
		reg_num     rd;
		reg_num     rn;
		reg_num     r_snd;
		reg_num     r_shift;
		logic [7:0] imm;
		logic [4:0] shift_imm;
		ptr         branch_offset;
	} alu_decode;

endpackage

`default_nettype wire

/* rtl/core_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_decode (
	input  logic                clk,
	input  logic                reset,
	input  logic                insn_valid,
	input  core_pkg::word       insn,
	input  core_pkg::ptr        insn_pc,
	input  logic                stall,
	output logic                insn_credit,
	output logic                dec_execute,
	output logic                dec_branch,
	output logic                dec_writeback,
	output logic                dec_update_flags,
	output core_pkg::alu_decode dec_alu,
	output core_pkg::ptr        fetch_insn_pc
);

	localparam int PTR_W = $clog2(`CORE_QUEUE_DEPTH);
	localparam int CNT_W = $clog2(`CORE_QUEUE_DEPTH + 1);

	core_pkg::word q_insn [`CORE_QUEUE_DEPTH];
	core_pkg::ptr  q_pc [`CORE_QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic pop, is_alu, is_branch;
	core_pkg::word head;

	// ********************
	// queue
	// ********************

	assign pop = (count != '0) && !stall;
	assign insn_credit = pop;

	always_ff @(posedge clk) begin
		if (insn_valid) begin
			q_insn[wr_ptr] <= insn;
			q_pc[wr_ptr] <= insn_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (insn_valid)
				wr_ptr <= (wr_ptr == PTR_W'(`CORE_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(`CORE_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			case ({insn_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ********************
	// field decode of the head entry
	// ********************

	assign head = q_insn[rd_ptr];
	assign fetch_insn_pc = q_pc[rd_ptr];
	assign is_alu = head[31:28] == core_pkg::CLASS_ALU;
	assign is_branch = head[31:28] == core_pkg::CLASS_BRANCH;

	always_comb begin
		dec_alu.execute = pop;
		dec_alu.branch = is_branch;
		dec_alu.writeback = is_alu;
		dec_alu.update_flags = is_alu & head[24];
		dec_alu.op = core_pkg::alu_op'(head[27:25]);
		dec_alu.snd = core_pkg::snd_mode'(head[23:22]);
		// branch bits overlap the operand fields
		if (!is_alu) begin
			dec_alu.op = core_pkg::OP_MOV;
			dec_alu.snd = core_pkg::SND_IMM;
		end
		dec_alu.rd = head[21:18];
		dec_alu.rn = head[17:14];
		dec_alu.r_snd = head[13:10];
		dec_alu.r_shift = head[9:6];
		dec_alu.imm = head[7:0];
		// imm shares the shift amount bits
		dec_alu.shift_imm = (dec_alu.snd == core_pkg::SND_IMM) ? 5'd0 : head[4:0];
		dec_alu.branch_offset = {{(`CORE_PTR_BITS - 24){head[23]}}, head[23:0]};
	end

	assign dec_execute = dec_alu.execute;
	assign dec_branch = dec_alu.branch;
	assign dec_writeback = dec_alu.writeback;
	assign dec_update_flags = dec_alu.update_flags;

endmodule

`default_nettype wire

/* rtl/core_cycles.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_cycles (
	input  logic                clk,
	input  logic                reset,
	input  logic                dec_execute,
	input  logic                dec_branch,
	input  logic                dec_writeback,
	input  logic                dec_update_flags,
	input  core_pkg::alu_decode dec_alu,
	input  core_pkg::ptr        fetch_insn_pc,
	input  core_pkg::word       rd_value_b,
	output logic                stall,
	output logic                branch,
	output logic                writeback,
	output logic                update_flags,
	output core_pkg::reg_num    rd,
	output core_pkg::reg_num    ra,
	output core_pkg::reg_num    rb,
	output core_pkg::alu_op     op,
	output core_pkg::ptr        branch_target,
	output core_pkg::word       alu_base,
	output logic [7:0]          alu_shift
);

	typedef enum logic {
		EXECUTE,
		RD_SHIFT
	} cycle_state;

	cycle_state cycle, next_cycle;

	logic wb_pending, flags_pending, snd_is_imm, shift_by_reg;
	logic [7:0] imm;
	logic [4:0] shift_imm;
	core_pkg::word saved_base;
	core_pkg::reg_num r_shift;

	always_comb begin
		next_cycle = EXECUTE;
		if (cycle == EXECUTE && shift_by_reg)
			next_cycle = RD_SHIFT;
	end

	// hold the queue while a second cycle is coming
	assign stall = next_cycle != EXECUTE;

	// results only count on the last cycle of an instruction
	assign writeback = wb_pending & ~stall;
	assign update_flags = flags_pending & ~stall;

	always_comb begin
		if (cycle == RD_SHIFT)
			alu_base = saved_base;
		else if (snd_is_imm)
			alu_base = {{(`CORE_WORD_BITS - 8){1'b0}}, imm};
		else
			alu_base = rd_value_b;

		if (cycle == RD_SHIFT)
			alu_shift = rd_value_b[7:0];
		else
			alu_shift = {3'b000, shift_imm};
	end

	// ********************
	// sequencer control
	// ********************

	always_ff @(posedge clk) begin
		if (reset) begin
			cycle <= EXECUTE;
			branch <= 1'b0;
			wb_pending <= 1'b0;
			flags_pending <= 1'b0;
			shift_by_reg <= 1'b0;
		end else begin
			cycle <= next_cycle;
			if (next_cycle == EXECUTE) begin
				branch <= dec_execute & dec_branch;
				wb_pending <= dec_execute & dec_writeback;
				flags_pending <= dec_execute & dec_update_flags;
				shift_by_reg <= dec_execute & ~dec_branch &
					(dec_alu.snd == core_pkg::SND_SHIFT_REG);
			end else begin
				branch <= 1'b0;
			end
		end
	end

	// ********************
	// operand latches
	// ********************

	always_ff @(posedge clk) begin
		if (next_cycle == EXECUTE && dec_execute) begin
			op <= dec_alu.op;
			rd <= dec_alu.rd;
			ra <= dec_alu.rn;
			rb <= dec_alu.r_snd;
			r_shift <= dec_alu.r_shift;
			imm <= dec_alu.imm;
			shift_imm <= dec_alu.shift_imm;
			snd_is_imm <= dec_alu.snd == core_pkg::SND_IMM;
			branch_target <= fetch_insn_pc + core_pkg::ptr'(2) + dec_alu.branch_offset;
		end

		// base was read in EXECUTE, now read the shift amount register
		if (next_cycle == RD_SHIFT) begin
			saved_base <= rd_value_b;
			rb <= r_shift;
		end
	end

endmodule

`default_nettype wire

/* rtl/core_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_regfile (
	input  logic             clk,
	input  logic             reset,
	input  core_pkg::reg_num ra,
	input  core_pkg::reg_num rb,
	output core_pkg::word    rd_value_a,
	output core_pkg::word    rd_value_b,
	input  logic             we,
	input  core_pkg::reg_num wa,
	input  core_pkg::word    wd
);

	core_pkg::word regs [`CORE_NUM_REGS];

	// reads see the array directly, writes land at the edge
	assign rd_value_a = regs[ra];
	assign rd_value_b = regs[rb];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CORE_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

endmodule

`default_nettype wire

/* rtl/core_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_alu (
	input  core_pkg::alu_op op,
	input  core_pkg::word   a,
	input  core_pkg::word   base,
	input  logic [7:0]      shift,
	output core_pkg::word   result,
	output logic            n,
	output logic            z
);

	localparam int SHIFT_W = $clog2(`CORE_WORD_BITS);

	core_pkg::word shifted;
	logic shift_out;

	// ********************
	// barrel shifter
	// ********************

	// any amount of a full word or more shifts everything out
	assign shift_out = shift >= 8'(`CORE_WORD_BITS);

	always_comb begin
		if (shift_out)
			shifted = '0;
		else
			shifted = base << shift[SHIFT_W-1:0];
	end

	// ********************
	// logic and arithmetic
	// ********************

	always_comb begin
		case (op)
			core_pkg::OP_ADD:
				result = a + shifted;
			core_pkg::OP_SUB:
				result = a - shifted;
			core_pkg::OP_AND:
				result = a & shifted;
			core_pkg::OP_ORR:
				result = a | shifted;
			core_pkg::OP_EOR:
				result = a ^ shifted;
			core_pkg::OP_MOV:
				result = shifted;
			default:
				result = shifted;
		endcase
	end

	assign n = result[`CORE_WORD_BITS-1];
	assign z = result == '0;

endmodule

`default_nettype wire

/* rtl/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top (
	input  logic             clk,
	input  logic             reset,
	input  logic             insn_valid,
	input  core_pkg::word    insn,
	input  core_pkg::ptr     insn_pc,
	output logic             insn_credit,
	output logic             stall,
	output logic             wb_valid,
	output core_pkg::reg_num wb_rd,
	output core_pkg::word    wb_value,
	output logic             branch,
	output core_pkg::ptr     branch_target,
	output logic             flag_n,
	output logic             flag_z
);

	logic dec_execute, dec_branch, dec_writeback, dec_update_flags;
	core_pkg::alu_decode dec_alu;
	core_pkg::ptr fetch_insn_pc;

	logic writeback, update_flags, alu_n, alu_z;
	core_pkg::reg_num rd, ra, rb;
	core_pkg::alu_op op;
	core_pkg::word alu_base, rd_value_a, rd_value_b, result;
	logic [7:0] alu_shift;

	core_decode decode (
		.clk(clk),
		.reset(reset),
		.insn_valid(insn_valid),
		.insn(insn),
		.insn_pc(insn_pc),
		.stall(stall),
		.insn_credit(insn_credit),
		.dec_execute(dec_execute),
		.dec_branch(dec_branch),
		.dec_writeback(dec_writeback),
		.dec_update_flags(dec_update_flags),
		.dec_alu(dec_alu),
		.fetch_insn_pc(fetch_insn_pc)
	);

	core_cycles cycles (
		.clk(clk),
		.reset(reset),
		.dec_execute(dec_execute),
		.dec_branch(dec_branch),
		.dec_writeback(dec_writeback),
		.dec_update_flags(dec_update_flags),
		.dec_alu(dec_alu),
		.fetch_insn_pc(fetch_insn_pc),
		.rd_value_b(rd_value_b),
		.stall(stall),
		.branch(branch),
		.writeback(writeback),
		.update_flags(update_flags),
		.rd(rd),
		.ra(ra),
		.rb(rb),
		.op(op),
		.branch_target(branch_target),
		.alu_base(alu_base),
		.alu_shift(alu_shift)
	);

	core_regfile regfile (
		.clk(clk),
		.reset(reset),
		.ra(ra),
		.rb(rb),
		.rd_value_a(rd_value_a),
		.rd_value_b(rd_value_b),
		.we(writeback),
		.wa(rd),
		.wd(result)
	);

	core_alu alu (
		.op(op),
		.a(rd_value_a),
		.base(alu_base),
		.shift(alu_shift),
		.result(result),
		.n(alu_n),
		.z(alu_z)
	);

	// flags and writeback port, both set at the end of the final cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			flag_n <= 1'b0;
			flag_z <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			if (update_flags) begin
				flag_n <= alu_n;
				flag_z <= alu_z;
			end
			wb_valid <= writeback;
		end
	end

	always_ff @(posedge clk) begin
		if (writeback) begin
			wb_rd <= rd;
			wb_value <= result;
		end
	end

endmodule

`default_nettype wire

/* tests/core_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_assertions #(
	parameter int CNT_W = $clog2(`CORE_QUEUE_DEPTH + 1)
) (
	input logic             clk,
	input logic             reset,
	input logic             insn_valid,
	input logic             stall,
	input logic [CNT_W-1:0] count
);

	// ********************
	// credit accounting
	// ********************

	count_bounded: assert property (@(posedge clk) disable iff (reset)
		count <= CNT_W'(`CORE_QUEUE_DEPTH))
		else $error("decode queue count %0d above its depth", count);

	// a source that keeps its credits never writes into a full queue
	no_write_when_full: assert property (@(posedge clk) disable iff (reset)
		count == CNT_W'(`CORE_QUEUE_DEPTH) |-> !insn_valid)
		else $error("instruction written into a full decode queue");

	// ********************
	// stall shape
	// ********************

	stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
		$rose(stall) |=> $fell(stall))
		else $error("stall held for more than one cycle");

endmodule

bind core_decode core_assertions assertions (
	.clk(clk),
	.reset(reset),
	.insn_valid(insn_valid),
	.stall(stall),
	.count(count)
);

`default_nettype wire

/* tests/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_tb;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;

	typedef struct packed {
		core_pkg::word insn;
		core_pkg::ptr  pc;
		logic [7:0]    test;
	} stim_row;

	typedef struct packed {
		logic             is_branch;
		core_pkg::reg_num rd;
		core_pkg::word    value;
		core_pkg::ptr     target;
		logic             n;
		logic             z;
	} result_entry;

	logic clk, reset, insn_valid;
	core_pkg::word insn;
	core_pkg::ptr insn_pc;
	logic insn_credit, stall, wb_valid, branch, flag_n, flag_z;
	core_pkg::reg_num wb_rd;
	core_pkg::word wb_value;
	core_pkg::ptr branch_target;

	stim_row rows[$];
	result_entry expected[$];
	core_pkg::word model_regs [`CORE_NUM_REGS];
	logic model_n, model_z;
	core_pkg::ptr next_pc;

	integer seed = 32'h22c0_d6e8;
	int errors = 0;
	int checks = 0;
	int credits = `CORE_QUEUE_DEPTH;
	int pending_credit = 0;
	int test_issued = 0;
	int test_returned = 0;
	int stall_cycles = 0;
	int shift_reg_issued = 0;
	bit table_ready = 1'b0;

	core_top dut (
		.clk(clk),
		.reset(reset),
		.insn_valid(insn_valid),
		.insn(insn),
		.insn_pc(insn_pc),
		.insn_credit(insn_credit),
		.stall(stall),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_value(wb_value),
		.branch(branch),
		.branch_target(branch_target),
		.flag_n(flag_n),
		.flag_z(flag_z)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected_value,
			input string what);
		checks++;
		if (actual !== expected_value) begin
			$display("[FAIL] %0t: %s: got 0x%h, expected 0x%h", $time, what, actual,
				expected_value);
			errors++;
		end
	endtask

	// ********************
	// instruction words
	// ********************

	function automatic core_pkg::word alu_word(core_pkg::alu_op op, int s,
			core_pkg::snd_mode snd, int rd, int rn, int rm, int low);
		core_pkg::word w;
		w = '0;
		w[31:28] = core_pkg::CLASS_ALU;
		w[27:25] = op;
		w[24] = 1'(s);
		w[23:22] = snd;
		w[21:18] = 4'(rd);
		w[17:14] = 4'(rn);
		w[13:10] = 4'(rm);
		w[9:0] = 10'(low);
		return w;
	endfunction

	function automatic core_pkg::word imm_word(core_pkg::alu_op op, int s, int rd, int rn,
			int imm);
		return alu_word(op, s, core_pkg::SND_IMM, rd, rn, 0, imm);
	endfunction

	function automatic core_pkg::word shift_imm_word(core_pkg::alu_op op, int s, int rd,
			int rn, int rm, int amount);
		return alu_word(op, s, core_pkg::SND_SHIFT_IMM, rd, rn, rm, amount);
	endfunction

	// shift register index sits in bits 9 to 6
	function automatic core_pkg::word shift_reg_word(core_pkg::alu_op op, int s, int rd,
			int rn, int rm, int rs);
		return alu_word(op, s, core_pkg::SND_SHIFT_REG, rd, rn, rm, rs * 64);
	endfunction

	function automatic core_pkg::word branch_word(int offset);
		return {core_pkg::CLASS_BRANCH, 4'h0, 24'(offset)};
	endfunction

	// ********************
	// reference model
	// ********************

	function automatic core_pkg::word shift_left(core_pkg::word base, logic [7:0] amount);
		if (amount >= 8'd32)
			return '0;
		else
			return base << amount[4:0];
	endfunction

	task automatic predict_result(input stim_row r);
		result_entry e;
		core_pkg::word w, operand, res;
		w = r.insn;
		e = '0;
		if (w[31:28] == core_pkg::CLASS_BRANCH) begin
			e.is_branch = 1'b1;
			e.target = r.pc + core_pkg::ptr'(2) + {{6{w[23]}}, w[23:0]};
		end else begin
			case (w[23:22])
				core_pkg::SND_IMM:
					operand = {24'd0, w[7:0]};
				core_pkg::SND_SHIFT_IMM:
					operand = shift_left(model_regs[w[13:10]], {3'd0, w[4:0]});
				default: begin
					operand = shift_left(model_regs[w[13:10]], model_regs[w[9:6]][7:0]);
					shift_reg_issued++;
				end
			endcase
			case (w[27:25])
				core_pkg::OP_ADD: res = model_regs[w[17:14]] + operand;
				core_pkg::OP_SUB: res = model_regs[w[17:14]] - operand;
				core_pkg::OP_AND: res = model_regs[w[17:14]] & operand;
				core_pkg::OP_ORR: res = model_regs[w[17:14]] | operand;
				core_pkg::OP_EOR: res = model_regs[w[17:14]] ^ operand;
				default: res = operand;
			endcase
			e.rd = w[21:18];
			e.value = res;
			model_regs[w[21:18]] = res;
			if (w[24]) begin
				model_n = res[31];
				model_z = (res == '0);
			end
		end
		e.n = model_n;
		e.z = model_z;
		expected.push_back(e);
	endtask

	// ********************
	// driver and monitor
	// ********************

	// one cycle, ending at the falling edge where outputs are settled
	task automatic step_cycle();
		result_entry e;
		@(negedge clk);
		insn_valid = 1'b0;
		// a credit seen in this cycle is spent from the next one on
		credits = credits + pending_credit;
		pending_credit = insn_credit ? 1 : 0;
		if (insn_credit)
			test_returned++;
		if (stall)
			stall_cycles++;
		if (wb_valid) begin
			if (expected.size() == 0) begin
				$display("%0t: writeback to r%0d with no instruction outstanding", $time,
					wb_rd);
				errors++;
			end else begin
				e = expected.pop_front();
				check_value(32'(e.is_branch), 32'd0, "writeback where a branch was expected");
				check_value(32'(wb_rd), 32'(e.rd), "wb_rd");
				check_value(wb_value, e.value, "wb_value");
				check_value(32'(flag_n), 32'(e.n), "flag_n");
				check_value(32'(flag_z), 32'(e.z), "flag_z");
			end
		end
		if (branch) begin
			if (expected.size() == 0) begin
				$display("%0t: branch with no instruction outstanding", $time);
				errors++;
			end else begin
				e = expected.pop_front();
				check_value(32'(e.is_branch), 32'd1, "branch where a writeback was expected");
				check_value(32'(branch_target), 32'(e.target), "branch_target");
			end
		end
	endtask

	task automatic issue_row(input stim_row r);
		int gap;
		gap = {$random(seed)} % 3;
		repeat (gap)
			step_cycle();
		while (credits == 0)
			step_cycle();
		insn = r.insn;
		insn_pc = r.pc;
		insn_valid = 1'b1;
		credits--;
		test_issued++;
		predict_result(r);
		step_cycle();
	endtask

	task automatic finish_test(input logic [7:0] test, input int errors_before);
		while (expected.size() != 0 || test_returned < test_issued)
			step_cycle();
		check_value(32'(test_returned), 32'(test_issued), "credits returned in test");
		if (errors == errors_before)
			$display("test %0d: %0d instructions, ok", test, test_issued);
		else
			$display("test %0d: %0d instructions, %0d mismatches", test, test_issued,
				errors - errors_before);
		test_issued = 0;
		test_returned = 0;
	endtask

	task automatic add_row(input logic [7:0] test, input core_pkg::word w);
		stim_row r;
		r.insn = w;
		r.pc = next_pc;
		r.test = test;
		rows.push_back(r);
		next_pc = next_pc + core_pkg::ptr'(1);
	endtask

	// ********************
	// stimulus table
	// ********************

	task automatic build_table();
		next_pc = core_pkg::ptr'('h100);
		// immediate moves
		add_row(1, imm_word(core_pkg::OP_MOV, 0, 1, 0, 'h5a));
		add_row(1, imm_word(core_pkg::OP_MOV, 1, 2, 0, 'hff));
		add_row(1, imm_word(core_pkg::OP_MOV, 0, 3, 0, 'h80));
		add_row(1, imm_word(core_pkg::OP_MOV, 0, 4, 0, 7));
		add_row(1, imm_word(core_pkg::OP_MOV, 0, 5, 0, 1));
		add_row(1, imm_word(core_pkg::OP_MOV, 1, 6, 0, 0));
		// shift by immediate, with and without S
		add_row(2, shift_imm_word(core_pkg::OP_ADD, 1, 7, 1, 2, 4));
		add_row(2, shift_imm_word(core_pkg::OP_SUB, 0, 8, 4, 3, 24));
		add_row(2, shift_imm_word(core_pkg::OP_SUB, 1, 9, 5, 4, 0));
		add_row(2, shift_imm_word(core_pkg::OP_AND, 1, 10, 2, 1, 1));
		add_row(2, shift_imm_word(core_pkg::OP_ORR, 0, 11, 3, 4, 31));
		add_row(2, shift_imm_word(core_pkg::OP_EOR, 1, 12, 1, 1, 0));
		add_row(2, shift_imm_word(core_pkg::OP_ADD, 0, 13, 9, 5, 0));
		// shift by register, amounts 7, 40, 3 from a wide value, and 32
		add_row(3, imm_word(core_pkg::OP_MOV, 0, 14, 0, 40));
		add_row(3, imm_word(core_pkg::OP_MOV, 0, 15, 0, 3));
		add_row(3, shift_imm_word(core_pkg::OP_ORR, 0, 15, 15, 2, 24));
		add_row(3, shift_reg_word(core_pkg::OP_MOV, 0, 0, 0, 1, 4));
		add_row(3, shift_reg_word(core_pkg::OP_ADD, 1, 2, 2, 5, 14));
		add_row(3, shift_reg_word(core_pkg::OP_SUB, 1, 3, 3, 1, 15));
		add_row(3, imm_word(core_pkg::OP_MOV, 0, 14, 0, 32));
		add_row(3, shift_reg_word(core_pkg::OP_EOR, 1, 13, 13, 11, 14));
		// branches
		add_row(4, branch_word(5));
		add_row(4, branch_word(-3));
		add_row(4, branch_word(0));
		add_row(4, branch_word(-8388608));
		// dependent chain
		add_row(5, imm_word(core_pkg::OP_MOV, 0, 1, 0, 1));
		add_row(5, shift_imm_word(core_pkg::OP_ADD, 0, 1, 1, 1, 1));
		add_row(5, shift_imm_word(core_pkg::OP_ADD, 0, 1, 1, 1, 1));
		add_row(5, shift_imm_word(core_pkg::OP_ADD, 1, 1, 1, 1, 1));
		add_row(5, imm_word(core_pkg::OP_MOV, 0, 3, 0, 2));
		add_row(5, shift_reg_word(core_pkg::OP_MOV, 0, 4, 0, 1, 3));
		add_row(5, shift_imm_word(core_pkg::OP_SUB, 1, 2, 4, 4, 0));
		add_row(5, shift_reg_word(core_pkg::OP_ORR, 0, 5, 4, 2, 3));
		// burst of mostly two-cycle instructions against the credit limit
		for (int i = 0; i < 16; i++) begin
			if (i % 4 == 3)
				add_row(6, imm_word(core_pkg::OP_MOV, 0, i, 0, i * 9));
			else
				add_row(6, shift_reg_word(core_pkg::alu_op'(i % 5), i % 2, (i + 1) % 16,
					i, (i + 3) % 16, (i + 5) % 16));
		end
	endtask

	initial begin
		int errors_before;
		clk = 1'b0;
		reset = 1'b1;
		insn_valid = 1'b0;
		insn = '0;
		insn_pc = '0;
		model_n = 1'b0;
		model_z = 1'b0;
		for (int i = 0; i < `CORE_NUM_REGS; i++)
			model_regs[i] = '0;
		build_table();
		table_ready = 1'b1;

		repeat (RESET_CYCLES)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		step_cycle();
		check_value(32'({wb_valid, branch, insn_credit, stall, flag_n, flag_z}), 32'd0,
			"outputs after reset");

		errors_before = errors;
		for (int i = 0; i < rows.size(); i++) begin
			if (i > 0 && rows[i].test != rows[i - 1].test) begin
				finish_test(rows[i - 1].test, errors_before);
				errors_before = errors;
			end
			issue_row(rows[i]);
		end
		finish_test(rows[rows.size() - 1].test, errors_before);
		check_value(32'(stall_cycles), 32'(shift_reg_issued), "stall cycles per shift by register");

		$display("%0d instructions, %0d checks, %0d errors", rows.size(), checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// watchdog
	initial begin
		int limit;
		wait (table_ready);
		limit = rows.size() * 40 + 200;
		#(limit * CLK_PERIOD);
		$display("run timed out after %0d cycles with results still outstanding", limit);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+rtl
rtl/core_pkg.sv
rtl/core_decode.sv
rtl/core_cycles.sv
rtl/core_regfile.sv
rtl/core_alu.sv
rtl/core_top.sv
tests/core_assertions.sv
tests/core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module core_tb -f compile.f -o core_sim

# a stopped simulation still has its output searched
output=$(./obj_dir/core_sim 2>&1 || true)
echo "$output"

echo "$output" | grep -qx "No errors"
